// File: include/tc_params.svh
`ifndef TC_PARAMS_SVH
`define TC_PARAMS_SVH

// partial-sum cache geometry.
`define TC_ROWS         16
`define TC_ROW_W        4
`define TC_LANES        4

// operands are signed bytes, partial sums wrap at 16 bits.
`define TC_DW_IN        8
`define TC_DW_ACC       16

// the sender starts with one credit per FIFO entry.
`define TC_CMD_DEPTH    4

// beats the consumer can absorb before it returns a credit.
`define TC_OUT_CREDITS  2

`endif

// File: design/tc_pkg.sv
`include "tc_params.svh"

package tc_pkg;

    // command kind encodings.
    localparam logic KIND_MAC   = 1'b0;
    localparam logic KIND_DRAIN = 1'b1;

    // one signed operand byte per lane.
    typedef logic [`TC_LANES-1:0][`TC_DW_IN-1:0] tc_bvec_t;

    // multiply-accumulate payload.
    typedef struct packed {
        logic [`TC_ROW_W-1:0]  row;
        logic [`TC_DW_IN-1:0]  a;     // shared by every lane.
        tc_bvec_t              b;
        logic [`TC_LANES-1:0]  mask;
    } tc_mac_t;

    localparam int TC_MAC_W = $bits(tc_mac_t);

    // drain payload. row lines up with the row field of a MAC.
    typedef struct packed {
        logic [`TC_ROW_W-1:0]             row;
        logic                             clear;
        logic [TC_MAC_W-`TC_ROW_W-2:0]    pad;
    } tc_drain_t;

    typedef union packed {
        tc_mac_t   mac;
        tc_drain_t drain;
    } tc_payload_u;

    typedef struct packed {
        logic        kind;      // 0 is a MAC, 1 is a drain.
        tc_payload_u payload;
    } tc_cmd_t;

    // decoded command as broadcast from the feeder to all lanes.
    typedef struct packed {
        logic                  valid;
        logic                  is_drain;
        logic                  clear;
        logic [`TC_ROW_W-1:0]  row;
        logic [`TC_DW_IN-1:0]  a;
        tc_bvec_t              b;
        logic [`TC_LANES-1:0]  mask;
    } tc_issue_t;

    // one partial sum per lane, used for lane results and output beats.
    typedef logic [`TC_LANES-1:0][`TC_DW_ACC-1:0] tc_row_t;

endpackage

// File: design/tc_cmd_feeder.sv
`timescale 1ns/1ps

`include "tc_params.svh"

module tc_cmd_feeder (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_valid,
    input  tc_pkg::tc_cmd_t   cmd,
    output logic              cmd_credit,
    input  logic              drain_ready,
    output tc_pkg::tc_issue_t issue,
    output logic              drain_issued
);
    import tc_pkg::*;

    localparam int PW   = $clog2(`TC_CMD_DEPTH);
    localparam int CNTW = $clog2(`TC_CMD_DEPTH + 1);

    tc_cmd_t         fifo_mem [`TC_CMD_DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CNTW-1:0] count;
    logic            empty;
    logic            full;
    logic            push;
    logic            pop;
    logic            head_is_drain;
    tc_cmd_t         head;
    tc_mac_t         head_mac;
    tc_drain_t       head_drain;
    tc_issue_t       next_issue;

    function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
        logic [PW-1:0] nxt;
        if (ptr == PW'(`TC_CMD_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNTW'(`TC_CMD_DEPTH));

    // the sender only sends on a held credit, so a full FIFO never sees a push.
    assign push = cmd_valid && !full;

    // a drain waits at the head until the output side can take its beat.
    assign head_is_drain = (head.kind == KIND_DRAIN);
    assign pop           = !empty && (!head_is_drain || drain_ready);

    always_comb begin
        head       = fifo_mem[rd_ptr];
        head_mac   = head.payload.mac;
        head_drain = head.payload.drain;

        next_issue          = '0;
        next_issue.valid    = 1'b1;
        next_issue.is_drain = head_is_drain;
        next_issue.row      = head_mac.row; // both views keep the row in the same bits.
        if (head_is_drain) begin
            next_issue.clear = head_drain.clear;
        end else begin
            next_issue.a    = head_mac.a;
            next_issue.b    = head_mac.b;
            next_issue.mask = head_mac.mask;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count <= count + CNTW'(push) - CNTW'(pop);
        end
    end

    // every pop frees an entry and so hands one credit back to the sender.
    always_ff @(posedge clk) begin
        if (rst) begin
            issue        <= '0;
            cmd_credit   <= 1'b0;
            drain_issued <= 1'b0;
        end else begin
            cmd_credit   <= pop;
            drain_issued <= pop && head_is_drain;
            if (pop) begin
                issue <= next_issue;
            end else begin
                issue.valid <= 1'b0;
            end
        end
    end

endmodule

// File: design/tc_psum_lane.sv
`timescale 1ns/1ps

`include "tc_params.svh"

module tc_psum_lane (
    input  logic                  clk,
    input  logic                  rst,
    input  tc_pkg::tc_issue_t     issue,
    input  logic [`TC_DW_IN-1:0]  b_lane,
    input  logic                  mask_lane,
    output logic                  lane_valid,
    output logic [`TC_DW_ACC-1:0] psum,
    output logic [`TC_ROW_W-1:0]  psum_row
);

    logic [`TC_DW_ACC-1:0]        col_mem [`TC_ROWS]; // this lane's column of partial sums.

    logic                         s1_valid;
    logic                         s1_drain;
    logic                         s1_clear;
    logic                         s1_mask;
    logic [`TC_ROW_W-1:0]         s1_row;
    logic signed [2*`TC_DW_IN-1:0] s1_prod;

    logic                         s2_mac;
    logic                         s2_drain;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
        end
    end

    // stage one forms the product and carries the command fields along.
    always_ff @(posedge clk) begin
        s1_drain <= issue.is_drain;
        s1_clear <= issue.clear;
        s1_mask  <= mask_lane;
        s1_row   <= issue.row;
        s1_prod  <= $signed(issue.a) * $signed(b_lane);
    end

    assign s2_mac   = s1_valid && !s1_drain && s1_mask;
    assign s2_drain = s1_valid && s1_drain;

    // stage two. a read and a clear of the same row happen at one edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `TC_ROWS; r++) begin
                col_mem[r] <= '0;
            end
            lane_valid <= 1'b0;
        end else begin
            lane_valid <= s2_drain;
            if (s2_drain && s1_clear) begin
                col_mem[s1_row] <= '0;
            end else if (s2_mac) begin
                col_mem[s1_row] <= col_mem[s1_row] + `TC_DW_ACC'(s1_prod); // wraps.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s2_drain) begin
            psum     <= col_mem[s1_row];
            psum_row <= s1_row;
        end
    end

endmodule

// File: design/tc_psum_drain.sv
`timescale 1ns/1ps

`include "tc_params.svh"

module tc_psum_drain (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  drain_issued,
    input  logic [`TC_LANES-1:0]  lane_valid,
    input  tc_pkg::tc_row_t       lane_psum,
    input  logic [`TC_ROW_W-1:0]  lane_row,
    input  logic                  out_credit,
    output logic                  drain_ready,
    output logic                  out_valid,
    output logic [`TC_ROW_W-1:0]  out_row,
    output tc_pkg::tc_row_t       out
);

    // wide enough for the in-flight count plus the drain issued this cycle.
    localparam int CW = $clog2(`TC_OUT_CREDITS + 2);

    logic [CW-1:0] credits;
    logic [CW-1:0] inflight;
    logic [CW-1:0] committed;
    logic          row_done;

    // every lane sees the same drain in the same cycle.
    assign row_done = &lane_valid;

    // a drain on the issue bus this cycle already claims its credit.
    assign committed   = inflight + CW'(drain_issued);
    assign drain_ready = (credits > committed);

    always_ff @(posedge clk) begin
        if (rst) begin
            credits  <= CW'(`TC_OUT_CREDITS);
            inflight <= '0;
        end else begin
            credits  <= credits + CW'(out_credit) - CW'(out_valid);
            inflight <= inflight + CW'(drain_issued) - CW'(out_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= row_done;
        end
    end

    always_ff @(posedge clk) begin
        if (row_done) begin
            out     <= lane_psum;
            out_row <= lane_row;
        end
    end

endmodule

// File: design/tc_top.sv
`timescale 1ns/1ps

`include "tc_params.svh"

module tc_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid,
    input  tc_pkg::tc_cmd_t      cmd,
    output logic                 cmd_credit,
    input  logic                 out_credit,
    output logic                 out_valid,
    output logic [`TC_ROW_W-1:0] out_row,
    output tc_pkg::tc_row_t      out
);
    import tc_pkg::*;

    tc_issue_t            issue;
    logic                 drain_issued;
    logic                 drain_ready;
    logic [`TC_LANES-1:0] lane_valid;
    tc_row_t              lane_psum;
    logic [`TC_ROW_W-1:0] lane_rows [`TC_LANES];

    tc_cmd_feeder u_feeder (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .cmd_credit   (cmd_credit),
        .drain_ready  (drain_ready),
        .issue        (issue),
        .drain_issued (drain_issued)
    );

    for (genvar gi = 0; gi < `TC_LANES; gi++) begin : g_lane
        localparam int lane_idx = gi;

        tc_psum_lane u_lane (
            .clk        (clk),
            .rst        (rst),
            .issue      (issue),
            .b_lane     (issue.b[lane_idx]),
            .mask_lane  (issue.mask[lane_idx]),
            .lane_valid (lane_valid[lane_idx]),
            .psum       (lane_psum[lane_idx]),
            .psum_row   (lane_rows[lane_idx])
        );
    end

    // all lanes carry the same row tag, lane 0 stands for the beat.
    tc_psum_drain u_drain (
        .clk          (clk),
        .rst          (rst),
        .drain_issued (drain_issued),
        .lane_valid   (lane_valid),
        .lane_psum    (lane_psum),
        .lane_row     (lane_rows[0]),
        .out_credit   (out_credit),
        .drain_ready  (drain_ready),
        .out_valid    (out_valid),
        .out_row      (out_row),
        .out          (out)
    );

endmodule

// File: test/tc_sva.sv
`timescale 1ns/1ps

`include "tc_params.svh"

module tc_sva (
    input logic clk,
    input logic rst,
    input logic cmd_valid,
    input logic cmd_credit,
    input logic out_valid,
    input logic out_credit
);

    int cmd_held; // command credits the sender still holds.
    int out_held; // output credits the drain side still holds.
    int fail_cnt = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_held <= `TC_CMD_DEPTH;
            out_held <= `TC_OUT_CREDITS;
        end else begin
            cmd_held <= cmd_held + int'(cmd_credit) - int'(cmd_valid);
            out_held <= out_held + int'(out_credit) - int'(out_valid);
        end
    end

    a_cmd_has_credit: assert property (
        @(posedge clk) disable iff (rst) cmd_valid |-> (cmd_held > 0)
    ) else begin
        $error("cmd_valid asserted while the sender holds no command credit");
        fail_cnt++;
    end

    a_out_has_credit: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> (out_held > 0)
    ) else begin
        $error("out_valid asserted while no output credit is held");
        fail_cnt++;
    end

    // nothing can have been drained this soon after reset.
    a_out_quiet_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> !out_valid ##1 !out_valid
    ) else begin
        $error("out_valid asserted within two cycles of reset release");
        fail_cnt++;
    end

endmodule

// File: test/tc_tb.sv
`timescale 1ns/1ps

`include "tc_params.svh"

module tc_tb;
    import tc_pkg::*;

    localparam int P1_MACS         = 40;
    localparam int P4_CMDS         = 20;
    localparam int NUM_CMDS        = P1_MACS + 8 + 16 + 24 + P4_CMDS;
    localparam int WATCHDOG_CYCLES = (NUM_CMDS + 50) * 8;
    localparam int HOLD_CYCLES     = 80;
    localparam int WINDOW          = 30; // tail of the hold where nothing may move.

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 cmd_valid;
    tc_cmd_t              cmd;
    logic                 cmd_credit;
    logic                 out_credit = 1'b0;
    logic                 out_valid;
    logic [`TC_ROW_W-1:0] out_row;
    tc_row_t              out;

    logic [`TC_DW_ACC-1:0] model [`TC_ROWS][`TC_LANES];
    tc_row_t               exp_q [$];
    logic [`TC_ROW_W-1:0]  exp_row_q [$];

    logic [15:0] stim_lfsr = 16'd66;
    logic [15:0] cr_lfsr = 16'd66;
    logic        hold_credit = 1'b0;
    int          owed = 0;       // beats received whose credit is not yet returned.
    int          sent_cnt = 0;
    int          drain_cnt = 0;
    int          credit_cnt = 0;
    int          beat_cnt = 0;
    int          err_cnt = 0;
    int          snap_beats;
    int          snap_credits;

    tc_top UUT (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_row    (out_row),
        .out        (out)
    );

    bind tc_top tc_sva u_sva (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_credit (cmd_credit),
        .out_valid  (out_valid),
        .out_credit (out_credit)
    );

    always #2 clk = ~clk;

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    function automatic logic [31:0] stim_rand(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            stim_lfsr = galois_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    // waits for a held credit, then presents the command for one cycle.
    task automatic send_cmd(input tc_cmd_t c);
        int avail;
        avail = 0;
        while (avail == 0) begin
            @(posedge clk);
            avail = `TC_CMD_DEPTH - sent_cnt + credit_cnt + int'(cmd_credit);
            if (avail == 0) begin
                cmd_valid <= 1'b0;
            end
        end
        cmd_valid <= 1'b1;
        cmd       <= c;
        sent_cnt++;
    endtask

    task automatic send_mac(input logic [`TC_ROW_W-1:0] row, input logic [`TC_LANES-1:0] mask);
        tc_cmd_t            c;
        logic signed [15:0] prod;
        c = '0;
        c.kind = KIND_MAC;
        c.payload.mac.row  = row;
        c.payload.mac.a    = `TC_DW_IN'(stim_rand(8));
        c.payload.mac.mask = mask;
        for (int l = 0; l < `TC_LANES; l++) begin
            c.payload.mac.b[l] = `TC_DW_IN'(stim_rand(8));
            if (mask[l]) begin
                prod = $signed(c.payload.mac.a) * $signed(c.payload.mac.b[l]);
                model[row][l] = model[row][l] + prod; // 16-bit wrap.
            end
        end
        send_cmd(c);
    endtask

    task automatic send_drain(input logic [`TC_ROW_W-1:0] row, input logic clear);
        tc_cmd_t c;
        tc_row_t r;
        c = '0;
        c.kind = KIND_DRAIN;
        c.payload.drain.row   = row;
        c.payload.drain.clear = clear;
        for (int l = 0; l < `TC_LANES; l++) begin
            r[l] = model[row][l];
            if (clear) begin
                model[row][l] = '0;
            end
        end
        exp_q.push_back(r);
        exp_row_q.push_back(row);
        drain_cnt++;
        send_cmd(c);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            cmd_valid <= 1'b0;
        end
    endtask

    // returns once every drain has come out and every credit has gone back.
    task automatic wait_drained();
        do begin
            @(posedge clk);
            cmd_valid <= 1'b0;
        end while (beat_cnt != drain_cnt || owed != 0);
    endtask

    always @(posedge clk) begin
        tc_row_t              exp_row;
        logic [`TC_ROW_W-1:0] exp_r;
        if (!rst && cmd_credit) begin
            credit_cnt <= credit_cnt + 1;
        end
        if (!rst && out_valid) begin
            beat_cnt <= beat_cnt + 1;
            if (exp_q.size() == 0) begin
                $display("an output beat for row %0d arrived with no drain outstanding", out_row);
                err_cnt++;
            end else begin
                exp_row = exp_q.pop_front();
                exp_r   = exp_row_q.pop_front();
                check_value("out_row", out_row, exp_r);
                for (int l = 0; l < `TC_LANES; l++) begin
                    check_value($sformatf("out[%0d]", l), out[l], exp_row[l]);
                end
            end
        end
    end

    // the consumer hands credits back after a random pause.
    always @(posedge clk) begin
        int next_owed;
        if (rst) begin
            out_credit <= 1'b0;
            owed       <= 0;
        end else begin
            next_owed = owed + int'(out_valid);
            cr_lfsr   = galois_step(cr_lfsr);
            if (!hold_credit && next_owed > 0 && cr_lfsr[0]) begin
                out_credit <= 1'b1;
                next_owed--;
            end else begin
                out_credit <= 1'b0;
            end
            owed <= next_owed;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("the run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        for (int r = 0; r < `TC_ROWS; r++) begin
            for (int l = 0; l < `TC_LANES; l++) begin
                model[r][l] = '0;
            end
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < P1_MACS; i++) begin
            send_mac(`TC_ROW_W'(stim_rand(3)), `TC_LANES'(stim_rand(4)));
            if (stim_rand(2) == 0) begin
                idle_cycles(1 + int'(stim_rand(2)));
            end
        end
        for (int r = 0; r < 8; r++) begin
            send_drain(`TC_ROW_W'(r), 1'b0);
        end
        wait_drained();

        for (int r = 0; r < 8; r++) begin
            send_drain(`TC_ROW_W'(r), 1'b1);
            send_drain(`TC_ROW_W'(r), 1'b0); // must come back as zeros.
        end
        wait_drained();

        for (int k = 0; k < 4; k++) begin
            for (int j = 0; j < 5; j++) begin
                send_mac(`TC_ROW_W'(8 + k), '1);
            end
            send_drain(`TC_ROW_W'(8 + k), stim_rand(1));
        end
        wait_drained();

        @(posedge clk);
        cmd_valid   <= 1'b0;
        hold_credit <= 1'b1;
        fork
            begin
                for (int k = 0; k < P4_CMDS; k++) begin
                    if (k % 3 == 2) begin
                        send_drain(`TC_ROW_W'(12 + stim_rand(2)), stim_rand(1));
                    end else begin
                        send_mac(`TC_ROW_W'(12 + stim_rand(2)), `TC_LANES'(stim_rand(4)));
                    end
                end
                @(posedge clk);
                cmd_valid <= 1'b0;
            end
            begin
                repeat (HOLD_CYCLES - WINDOW) @(posedge clk);
                snap_beats   = beat_cnt;
                snap_credits = credit_cnt;
                repeat (WINDOW) @(posedge clk);
                check_value("out_valid beats while held", beat_cnt, snap_beats);
                check_value("cmd_credit pulses while held", credit_cnt, snap_credits);
                hold_credit <= 1'b0;
            end
        join
        wait_drained();
        idle_cycles(8);

        check_value("cmd_credit pulses", credit_cnt, sent_cnt);
        check_value("out_valid beats", beat_cnt, drain_cnt);
        err_cnt = err_cnt + UUT.u_sva.fail_cnt;

        $display("errors: %0d, commands: %0d, drains: %0d, beats: %0d",
                 err_cnt, sent_cnt, drain_cnt, beat_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
design/tc_pkg.sv
design/tc_cmd_feeder.sv
design/tc_psum_lane.sv
design/tc_psum_drain.sv
design/tc_top.sv
test/tc_sva.sv
test/tc_tb.sv
